/* src/exu_pkg.sv */
package exu_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xword_t;  // one operand or result word
    typedef logic [31:0]     half_t;   // low half used by word mode
    typedef logic [5:0]      shamt_t;  // shift amount, 6 bits for rv64

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_divu = 4'd10,
        op_remu = 4'd11,
        op_mul  = 4'd12,
        op_cmp  = 4'd13   // branch test, see cmp_e
    } alu_op_e;

    typedef enum logic [2:0] {
        cmp_eq  = 3'd0,
        cmp_ne  = 3'd1,
        cmp_lt  = 3'd2,
        cmp_ge  = 3'd3,
        cmp_ltu = 3'd4,
        cmp_geu = 3'd5
    } cmp_e;

    // final extension of the result
    typedef enum logic [1:0] {
        ext_none   = 2'd0,
        ext_w_sign = 2'd1,
        ext_w_zero = 2'd2,
        ext_h_sign = 2'd3
    } ext_e;

    typedef struct packed {
        alu_op_e op;
        cmp_e    cmp;
        logic    word;  // low 32 bits only, sign-extended result
        ext_e    ext;
        xword_t  src1;
        xword_t  src2;
    } exu_req_t;

    typedef struct packed {
        xword_t result;
        logic   cond;     // branch taken, op_cmp only
    } exu_rsp_t;

endpackage

/* src/alu.sv */
`timescale 1ns/10ps

module alu (
    input  exu_pkg::exu_req_t req,
    output exu_pkg::exu_rsp_t rsp
);

    exu_pkg::xword_t a;      // signed view of the operands
    exu_pkg::xword_t b;
    exu_pkg::xword_t ua;     // unsigned view, zero-extended in word mode
    exu_pkg::xword_t ub;
    exu_pkg::half_t  lo1;
    exu_pkg::half_t  lo2;
    exu_pkg::shamt_t shamt;
    exu_pkg::xword_t quot;
    exu_pkg::xword_t rem;
    exu_pkg::xword_t res;
    exu_pkg::xword_t res_w;  // after word mode sign extension
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond;

    assign lo1 = req.src1[31:0];
    assign lo2 = req.src2[31:0];

    always_comb begin
        if (req.word) begin
            a     = {{32{lo1[31]}}, lo1};
            b     = {{32{lo2[31]}}, lo2};
            ua    = {32'b0, lo1};
            ub    = {32'b0, lo2};
            shamt = {1'b0, lo2[4:0]};  // word shifts use 5 bits
        end else begin
            a     = req.src1;
            b     = req.src2;
            ua    = req.src1;
            ub    = req.src2;
            shamt = req.src2[5:0];
        end
    end

    // sign extension keeps unsigned order, so word compares work on a and b
    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        if (ub == '0) begin
            quot = '1;   // rv divide by zero
            rem  = ua;   // remainder is the dividend
        end else begin
            quot = ua / ub;
            rem  = ua % ub;
        end
    end

    always_comb begin
        case (req.cmp)
            exu_pkg::cmp_eq:  cond = eq;
            exu_pkg::cmp_ne:  cond = !eq;
            exu_pkg::cmp_lt:  cond = lt_s;
            exu_pkg::cmp_ge:  cond = !lt_s;
            exu_pkg::cmp_ltu: cond = lt_u;
            exu_pkg::cmp_geu: cond = !lt_u;
            default:          cond = 1'b0;
        endcase
    end

    always_comb begin
        case (req.op)
            exu_pkg::op_add:  res = a + b;
            exu_pkg::op_sub:  res = a - b;
            exu_pkg::op_and:  res = a & b;
            exu_pkg::op_or:   res = a | b;
            exu_pkg::op_xor:  res = a ^ b;
            exu_pkg::op_sll:  res = a << shamt;
            exu_pkg::op_srl:  res = ua >> shamt;           // zeros come in from bit 31 in word mode
            exu_pkg::op_sra:  res = $signed(a) >>> shamt;
            exu_pkg::op_slt:  res = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
            exu_pkg::op_sltu: res = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
            exu_pkg::op_divu: res = quot;
            exu_pkg::op_remu: res = rem;
            exu_pkg::op_cmp:  res = {{(exu_pkg::xlen-1){1'b0}}, cond};
            // product arrives later as src1 with op_add
            exu_pkg::op_mul:  res = '0;
            default:          res = '0;
        endcase
    end

    assign res_w = req.word ? {{32{res[31]}}, res[31:0]} : res;

    always_comb begin
        case (req.ext)
            exu_pkg::ext_none:   rsp.result = res_w;
            exu_pkg::ext_w_sign: rsp.result = {{32{res_w[31]}}, res_w[31:0]};
            exu_pkg::ext_w_zero: rsp.result = {32'b0, res_w[31:0]};
            exu_pkg::ext_h_sign: rsp.result = {{48{res_w[15]}}, res_w[15:0]};
            default:             rsp.result = res_w;
        endcase
        rsp.cond = (req.op == exu_pkg::op_cmp) && cond;
    end

endmodule

/* src/mul.sv */
`timescale 1ns/10ps

module mul #(
    parameter int MUL_STEP = 2   // multiplier bits retired per cycle
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  exu_pkg::xword_t src1,
    input  exu_pkg::xword_t src2,
    output logic            done,
    output exu_pkg::xword_t product
);

    localparam int steps = exu_pkg::xlen / MUL_STEP;
    localparam int cnt_w = $clog2(steps);

    exu_pkg::xword_t  mcand;   // multiplicand, moves left
    exu_pkg::xword_t  mplier;  // multiplier, moves right
    exu_pkg::xword_t  acc;
    logic [cnt_w-1:0] cnt;     // steps left after the current one
    logic             running;

    // sum of the partial products for the low MUL_STEP multiplier bits
    function automatic exu_pkg::xword_t partial(
        input exu_pkg::xword_t mc,
        input exu_pkg::xword_t mp
    );
        exu_pkg::xword_t sum;
        sum = '0;
        for (int i = 0; i < MUL_STEP; i++) begin
            if (mp[i]) begin
                sum = sum + (mc << i);
            end
        end
        return sum;
    endfunction

    // first step is taken on the start edge itself
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= partial(src1, src2);
            mcand  <= src1 << MUL_STEP;
            mplier <= src2 >> MUL_STEP;
        end else if (running) begin
            acc    <= acc + partial(mcand, mplier);
            mcand  <= mcand << MUL_STEP;
            mplier <= mplier >> MUL_STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= cnt_w'(steps - 2);
            end else if (running) begin
                if (cnt == '0) begin
                    running <= 1'b0;
                    done    <= 1'b1;   // last step lands together with done
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // only the low xlen bits are kept
    assign product = acc;

endmodule

/* src/exu_ctrl.sv */
`timescale 1ns/10ps

module exu_ctrl #(
    parameter int MUL_STEP = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  exu_pkg::exu_req_t req,
    output logic              busy,
    output exu_pkg::exu_req_t alu_req,
    input  exu_pkg::exu_rsp_t alu_rsp,
    output logic              mul_start,
    output exu_pkg::xword_t   mul_src1,
    output exu_pkg::xword_t   mul_src2,
    input  logic              mul_done,
    input  exu_pkg::xword_t   mul_product,
    output logic              rsp_valid,
    output exu_pkg::exu_rsp_t rsp
);

    typedef enum logic {
        st_idle,
        st_mul
    } state_e;

    state_e        state;
    logic          accept;
    logic          is_mul;
    logic          rsp_load;
    logic          mul_word;  // word and ext of the multiply in flight
    exu_pkg::ext_e mul_ext;

    // the multiplier shift pattern only covers these step sizes
    if (!(MUL_STEP == 1 || MUL_STEP == 2 || MUL_STEP == 4)) begin : g_step_check
        $error("exu_ctrl: MUL_STEP must be 1, 2 or 4");
    end

    assign accept    = req_valid && (state == st_idle);  // dropped while busy
    assign is_mul    = (req.op == exu_pkg::op_mul);
    assign mul_start = accept && is_mul;
    assign mul_src1  = req.src1;
    assign mul_src2  = req.src2;
    assign busy      = (state == st_mul);
    assign rsp_load  = (accept && !is_mul) || (busy && mul_done);

    // product reuses the alu extension path as product + 0
    always_comb begin
        if (state == st_mul) begin
            alu_req.op   = exu_pkg::op_add;
            alu_req.cmp  = exu_pkg::cmp_eq;
            alu_req.word = mul_word;
            alu_req.ext  = mul_ext;
            alu_req.src1 = mul_product;
            alu_req.src2 = '0;
        end else begin
            alu_req = req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rsp_load;
            case (state)
                st_idle: if (mul_start) state <= st_mul;
                st_mul:  if (mul_done) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) rsp <= alu_rsp;  // held until the next response
        if (mul_start) begin
            mul_word <= req.word;
            mul_ext  <= req.ext;
        end
    end

endmodule

/* src/exu_top.sv */
`timescale 1ns/10ps

module exu_top #(
    parameter int MUL_STEP = 2   // 1, 2 or 4 bits per multiply cycle
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  exu_pkg::exu_req_t req,
    output logic              rsp_valid,
    output exu_pkg::exu_rsp_t rsp,
    output logic              busy
);

    exu_pkg::exu_req_t alu_req;
    exu_pkg::exu_rsp_t alu_rsp;
    logic              mul_start;
    exu_pkg::xword_t   mul_src1;
    exu_pkg::xword_t   mul_src2;
    logic              mul_done;
    exu_pkg::xword_t   mul_product;

    exu_ctrl #(.MUL_STEP(MUL_STEP)) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .alu_req     (alu_req),
        .alu_rsp     (alu_rsp),
        .mul_start   (mul_start),
        .mul_src1    (mul_src1),
        .mul_src2    (mul_src2),
        .mul_done    (mul_done),
        .mul_product (mul_product),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    alu u_alu (
        .req (alu_req),
        .rsp (alu_rsp)
    );

    mul #(.MUL_STEP(MUL_STEP)) u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .src1    (mul_src1),
        .src2    (mul_src2),
        .done    (mul_done),
        .product (mul_product)
    );

endmodule

/* bench/exu_props.sv */
`timescale 1ns/10ps

module exu_props (
    input logic              clk,
    input logic              rst_n,
    input logic              req_valid,
    input exu_pkg::exu_req_t req,
    input logic              rsp_valid,
    input logic              busy
);

    logic pending;       // accepted request still waiting for its response
    int   bad_rsp  = 0;
    int   bad_busy = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (req_valid && !busy) begin
            pending <= 1'b1;
        end else if (rsp_valid) begin
            pending <= 1'b0;
        end
    end

    a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> pending)
        else begin
            bad_rsp++;
            $error("rsp_valid without an accepted request");
        end

    // busy only follows an accepted multiply
    a_busy_after_mul: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(req_valid && !busy && req.op == exu_pkg::op_mul))
        else begin
            bad_busy++;
            $error("busy rose without a multiply request");
        end

endmodule

bind exu_top exu_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .busy      (busy)
);

/* bench/exu_model.svh */
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// branch condition, zero for anything but op_cmp
function automatic logic model_cond(input exu_pkg::exu_req_t r);
    logic eq;
    logic lt_s;
    logic lt_u;
    if (r.word) begin
        eq   = (r.src1[31:0] == r.src2[31:0]);
        lt_s = ($signed(r.src1[31:0]) < $signed(r.src2[31:0]));
        lt_u = (r.src1[31:0] < r.src2[31:0]);
    end else begin
        eq   = (r.src1 == r.src2);
        lt_s = ($signed(r.src1) < $signed(r.src2));
        lt_u = (r.src1 < r.src2);
    end
    if (r.op != exu_pkg::op_cmp) return 1'b0;
    case (r.cmp)
        exu_pkg::cmp_eq:  return eq;
        exu_pkg::cmp_ne:  return !eq;
        exu_pkg::cmp_lt:  return lt_s;
        exu_pkg::cmp_ge:  return !lt_s;
        exu_pkg::cmp_ltu: return lt_u;
        exu_pkg::cmp_geu: return !lt_u;
        default:          return 1'b0;
    endcase
endfunction

function automatic exu_pkg::xword_t model_result(input exu_pkg::exu_req_t r);
    logic [31:0]     x32;
    logic [31:0]     y32;
    logic [31:0]     v32;
    exu_pkg::xword_t x;
    exu_pkg::xword_t y;
    exu_pkg::xword_t v;
    x   = r.src1;
    y   = r.src2;
    x32 = x[31:0];
    y32 = y[31:0];
    if (r.word) begin
        case (r.op)  // 32-bit arithmetic, sign-extended below
            exu_pkg::op_add:  v32 = x32 + y32;
            exu_pkg::op_sub:  v32 = x32 - y32;
            exu_pkg::op_and:  v32 = x32 & y32;
            exu_pkg::op_or:   v32 = x32 | y32;
            exu_pkg::op_xor:  v32 = x32 ^ y32;
            exu_pkg::op_sll:  v32 = x32 << y32[4:0];
            exu_pkg::op_srl:  v32 = x32 >> y32[4:0];
            exu_pkg::op_sra:  v32 = $signed(x32) >>> y32[4:0];
            exu_pkg::op_slt:  v32 = {31'b0, $signed(x32) < $signed(y32)};
            exu_pkg::op_sltu: v32 = {31'b0, x32 < y32};
            exu_pkg::op_divu: v32 = (y32 == '0) ? '1 : x32 / y32;
            exu_pkg::op_remu: v32 = (y32 == '0) ? x32 : x32 % y32;
            exu_pkg::op_mul:  v32 = x32 * y32;
            exu_pkg::op_cmp:  v32 = {31'b0, model_cond(r)};
            default:          v32 = '0;
        endcase
        v = {{32{v32[31]}}, v32};
    end else begin
        case (r.op)
            exu_pkg::op_add:  v = x + y;
            exu_pkg::op_sub:  v = x - y;
            exu_pkg::op_and:  v = x & y;
            exu_pkg::op_or:   v = x | y;
            exu_pkg::op_xor:  v = x ^ y;
            exu_pkg::op_sll:  v = x << y[5:0];
            exu_pkg::op_srl:  v = x >> y[5:0];
            exu_pkg::op_sra:  v = $signed(x) >>> y[5:0];
            exu_pkg::op_slt:  v = {63'b0, $signed(x) < $signed(y)};
            exu_pkg::op_sltu: v = {63'b0, x < y};
            exu_pkg::op_divu: v = (y == '0) ? '1 : x / y;
            exu_pkg::op_remu: v = (y == '0) ? x : x % y;
            exu_pkg::op_mul:  v = x * y;   // low 64 bits only
            exu_pkg::op_cmp:  v = {63'b0, model_cond(r)};
            default:          v = '0;
        endcase
    end
    case (r.ext)
        exu_pkg::ext_w_sign: v = {{32{v[31]}}, v[31:0]};
        exu_pkg::ext_w_zero: v = {32'b0, v[31:0]};
        exu_pkg::ext_h_sign: v = {{48{v[15]}}, v[15:0]};
        default:             v = v;
    endcase
    return v;
endfunction

`endif

/* bench/exu_tb.sv */
`timescale 1ns/10ps

module exu_tb;

    localparam int mul_step    = 2;
    localparam int mul_steps   = exu_pkg::xlen / mul_step;
    localparam int cycle_limit = 600 * (mul_steps + 3);  // 600 requests at most

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    exu_pkg::exu_req_t req;
    logic              rsp_valid;
    exu_pkg::exu_rsp_t rsp;
    logic              busy;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    `include "exu_model.svh"

    exu_top #(.MUL_STEP(mul_step)) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .busy      (busy)
    );

    always #20 clk = !clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // mostly random with the odd sign boundary or small value
    function automatic exu_pkg::xword_t rand_word();
        case ($urandom_range(0, 7))
            0:       return 64'h8000_0000_0000_0000;
            1:       return 64'h0000_0000_8000_0000;
            2:       return 64'($urandom_range(0, 15));
            3:       return '1;
            default: return {$urandom(), $urandom()};
        endcase
    endfunction

    function automatic exu_pkg::exu_req_t make_req(input exu_pkg::alu_op_e op);
        exu_pkg::exu_req_t r;
        r.op   = op;
        r.cmp  = exu_pkg::cmp_e'($urandom_range(0, 5));
        r.word = 1'($urandom_range(0, 1));
        r.ext  = exu_pkg::ext_none;
        r.src1 = rand_word();
        r.src2 = rand_word();
        return r;
    endfunction

    // one strobe then wait for the single-cycle response
    task automatic run_req(input exu_pkg::exu_req_t r);
        exu_pkg::xword_t exp_res;
        logic            exp_cond;
        logic            exp_busy;
        int              exp_lat;
        int              lat;
        exp_res  = model_result(r);
        exp_cond = model_cond(r);
        exp_lat  = (r.op == exu_pkg::op_mul) ? mul_steps + 1 : 1;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        lat = 0;
        do begin
            @(posedge clk);
            req_valid <= 1'b0;
            lat++;
            @(negedge clk);
            exp_busy = (r.op == exu_pkg::op_mul) && !rsp_valid;
            if (busy !== exp_busy) begin
                errors++;
                $display("error busy got %h expected %h", busy, exp_busy);
            end
        end while (!rsp_valid && lat <= exp_lat + 2);
        checks++;
        if (!rsp_valid) begin
            errors++;
            $display("no response for op %0d within %0d cycles", r.op, lat);
        end else begin
            if (lat != exp_lat) begin
                errors++;
                $display("rsp_valid came %0d cycles after the strobe, expected %0d", lat, exp_lat);
            end
            if (rsp.result !== exp_res) begin
                errors++;
                $display("error rsp.result got %h expected %h (op %0d word %0d ext %0d)",
                         rsp.result, exp_res, r.op, r.word, r.ext);
            end
            if (rsp.cond !== exp_cond) begin
                errors++;
                $display("error rsp.cond got %h expected %h (cmp %0d)", rsp.cond, exp_cond, r.cmp);
            end
        end
        @(negedge clk);
        if (rsp_valid) begin
            errors++;
            $display("rsp_valid stayed high for more than one cycle");
        end
    endtask

    initial begin
        exu_pkg::exu_req_t r;
        int                prop_fails;
        void'($urandom(32'he6861b1e));
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (rsp_valid !== 1'b0) begin
            errors++;
            $display("error rsp_valid got %h expected 0 after reset", rsp_valid);
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("error busy got %h expected 0 after reset", busy);
        end

        repeat (200) run_req(make_req(exu_pkg::alu_op_e'($urandom_range(0, 9))));

        for (int c = 0; c < 6; c++) begin
            r = make_req(exu_pkg::op_cmp);
            r.cmp  = exu_pkg::cmp_e'(c);
            r.src2 = r.src1;             // equal operands
            run_req(r);
            r.word = 1'b0;
            r.src1 = 64'h8000_0000_0000_0000;
            r.src2 = 64'h7fff_ffff_ffff_ffff;
            run_req(r);
            r.word = 1'b1;
            r.src1 = 64'h0000_0000_8000_0000;  // word sign boundary
            r.src2 = 64'h0000_0000_7fff_ffff;
            run_req(r);
        end
        repeat (40) run_req(make_req(exu_pkg::op_cmp));

        r = make_req(exu_pkg::op_divu);
        r.src2 = '0;
        run_req(r);
        r.op = exu_pkg::op_remu;
        run_req(r);
        r.src1 = '1;
        r.src2 = 64'd3;
        run_req(r);
        r.op = exu_pkg::op_divu;
        run_req(r);
        repeat (60) run_req(make_req(exu_pkg::alu_op_e'($urandom_range(10, 11))));

        repeat (40) run_req(make_req(exu_pkg::op_mul));

        repeat (80) begin
            r = make_req(exu_pkg::alu_op_e'($urandom_range(0, 12)));
            r.ext = exu_pkg::ext_e'($urandom_range(0, 3));
            run_req(r);
        end

        prop_fails = UUT.u_props.bad_rsp + UUT.u_props.bad_busy;
        $display("%0d responses checked, %0d errors, %0d assertion failures",
                 checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+bench
src/exu_pkg.sv
src/alu.sv
src/mul.sv
src/exu_ctrl.sv
src/exu_top.sv
bench/exu_props.sv
bench/exu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the execute unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exu_tb -Mdir obj_dir -f vlog.f \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/Vexu_tb)"
echo "$sim_out"

echo "$sim_out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
